//--- src/bru_defs.svh
// Width and reset-value macros for the branch resolution slice.
`ifndef BRU_DEFS_SVH
`define BRU_DEFS_SVH

// --------------------------------------------------
// Datapath widths
// --------------------------------------------------
`define BRU_WORD_WD 64 // Register operand width.
`define BRU_PC_WD 64 // Program counter width.
`define BRU_IMM_WD 64 // Sign-extended immediate width.

// --------------------------------------------------
// Reset values
// --------------------------------------------------
`define BRU_RESET_PC 64'h8000_0000 // First fetch address.
`define BRU_RESET_MTVEC 64'h8000_0100 // Trap vector out of reset.

`endif

//--- src/bru_pkg.sv
// Shared types for the decoder, branch unit and trap registers.
`include "bru_defs.svh"

package bru_pkg;

  // --------------------------------------------------
  // Vector types
  // --------------------------------------------------
  typedef logic [`BRU_WORD_WD-1:0] word_t;
  typedef logic [`BRU_PC_WD-1:0] pc_t;
  typedef logic [`BRU_IMM_WD-1:0] imm_t;
  typedef logic [31:0] instr_t;

  // Branch function code as seen by the branch unit.
  typedef enum logic [2:0] {
    JAL  = 3'b000,
    JALR = 3'b001,
    BEQ  = 3'b010,
    BNE  = 3'b011,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } br_func_e;

  // Exception next-PC source.
  typedef enum logic [1:0] {
    NONE  = 2'b00,
    ECALL = 2'b01,
    MRET  = 2'b10
  } ep_kind_e;

endpackage

//--- src/branch_decode.sv
// Instruction decoder for control transfers: branch function, immediate, ecall and mret.
`include "bru_defs.svh"

module branch_decode (
  input  bru_pkg::instr_t   i_instr,
  output logic              o_bren,
  output bru_pkg::br_func_e o_brfunc,
  output bru_pkg::imm_t     o_imm,
  output bru_pkg::ep_kind_e o_ep_kind
);

  logic [6:0] opcode;
  logic [2:0] funct3;

  assign opcode = i_instr[6:0];
  assign funct3 = i_instr[14:12];

  // --------------------------------------------------
  // Branch enable and function code
  // --------------------------------------------------
  always_comb begin
    o_bren   = 1'b0;
    o_brfunc = bru_pkg::JAL; // Base is the PC when not a branch.
    case (opcode)
      7'b1101111: begin // JAL.
        o_bren   = 1'b1;
        o_brfunc = bru_pkg::JAL;
      end
      7'b1100111: begin // JALR.
        o_bren   = (funct3 == 3'b000);
        o_brfunc = bru_pkg::JALR;
      end
      7'b1100011: begin // Conditional branches.
        o_bren = 1'b1;
        case (funct3)
          3'b000:  o_brfunc = bru_pkg::BEQ;
          3'b001:  o_brfunc = bru_pkg::BNE;
          3'b100:  o_brfunc = bru_pkg::BLT;
          3'b101:  o_brfunc = bru_pkg::BGE;
          3'b110:  o_brfunc = bru_pkg::BLTU;
          3'b111:  o_brfunc = bru_pkg::BGEU;
          default: o_bren   = 1'b0; // Reserved funct3.
        endcase
      end
      default: ;
    endcase
  end

  // --------------------------------------------------
  // Immediate, sign extended from bit 31
  // --------------------------------------------------
  always_comb begin
    case (opcode)
      7'b1101111: o_imm = {{(`BRU_IMM_WD-21){i_instr[31]}}, i_instr[31], i_instr[19:12],
                           i_instr[20], i_instr[30:21], 1'b0}; // J-type.
      7'b1100011: o_imm = {{(`BRU_IMM_WD-13){i_instr[31]}}, i_instr[31], i_instr[7],
                           i_instr[30:25], i_instr[11:8], 1'b0}; // B-type.
      default:    o_imm = {{(`BRU_IMM_WD-12){i_instr[31]}}, i_instr[31:20]}; // I-type.
    endcase
  end

  // Exact encodings only.
  always_comb begin
    if (i_instr == 32'h0000_0073) o_ep_kind = bru_pkg::ECALL;
    else if (i_instr == 32'h3020_0073) o_ep_kind = bru_pkg::MRET;
    else o_ep_kind = bru_pkg::NONE;
  end

endmodule

//--- src/branch_unit.sv
// Branch unit that compares operands and resolves the taken flag and target.
`include "bru_defs.svh"

module branch_unit (
  input  bru_pkg::word_t    i_rs1data,
  input  bru_pkg::word_t    i_rs2data,
  input  bru_pkg::pc_t      i_pc,
  input  bru_pkg::imm_t     i_imm,
  input  logic              i_bren,
  input  bru_pkg::br_func_e i_brfunc,
  input  logic              i_ep_sel,
  input  bru_pkg::pc_t      i_epnpc,
  output logic              o_br_taken,
  output bru_pkg::pc_t      o_br_target
);

  bru_pkg::word_t sub_result;
  logic           cout;
  logic           overflow;
  logic           zero;
  logic           signed_less;
  logic           unsigned_less;
  logic           less;
  logic           cond;
  logic           base_rs1;
  logic           take;
  bru_pkg::pc_t   base;
  bru_pkg::pc_t   offset;

  // --------------------------------------------------
  // Single subtractor for rs1 minus rs2
  // --------------------------------------------------
  assign {cout, sub_result} = {1'b0, i_rs1data} + {1'b0, ~i_rs2data} + 1'b1;

  assign zero     = ~(|sub_result);
  assign overflow = (i_rs1data[`BRU_WORD_WD-1] ^ i_rs2data[`BRU_WORD_WD-1])
                  & (sub_result[`BRU_WORD_WD-1] ^ i_rs1data[`BRU_WORD_WD-1]);

  assign signed_less   = sub_result[`BRU_WORD_WD-1] ^ overflow;
  assign unsigned_less = ~cout; // No borrow means rs1 >= rs2.

  // --------------------------------------------------
  // Per-function lookups
  // --------------------------------------------------
  always_comb begin
    case (i_brfunc)
      bru_pkg::BLTU, bru_pkg::BGEU: less = unsigned_less;
      bru_pkg::JAL, bru_pkg::JALR:  less = 1'b0;
      default:                      less = signed_less;
    endcase
  end

  always_comb begin
    case (i_brfunc)
      bru_pkg::BEQ:                 cond = zero;
      bru_pkg::BNE:                 cond = ~zero;
      bru_pkg::BLT, bru_pkg::BLTU:  cond = less;
      bru_pkg::BGE, bru_pkg::BGEU:  cond = ~less;
      default:                      cond = 1'b1; // Jumps always go.
    endcase
  end

  always_comb begin
    case (i_brfunc)
      bru_pkg::JALR: base_rs1 = 1'b1;
      default:       base_rs1 = 1'b0;
    endcase
  end

  // --------------------------------------------------
  // Taken and target
  // --------------------------------------------------
  assign take   = i_bren & cond;
  assign base   = base_rs1 ? i_rs1data : i_pc;
  assign offset = take ? i_imm : bru_pkg::pc_t'(4);

  assign o_br_taken  = take | i_ep_sel;
  assign o_br_target = i_ep_sel ? i_epnpc : base + offset; // Exception next-PC wins.

endmodule

//--- src/trap_csr.sv
// Machine trap registers mtvec, mepc and mcause with the exception next-PC select.
`include "bru_defs.svh"

module trap_csr (
  input  logic              i_clk,
  input  logic              i_reset,
  input  logic              i_valid,
  input  bru_pkg::ep_kind_e i_ep_kind,
  input  bru_pkg::pc_t      i_pc,
  input  logic              i_mtvec_we,
  input  bru_pkg::pc_t      i_mtvec_wdata,
  output logic              o_ep_sel,
  output bru_pkg::pc_t      o_epnpc
);

  bru_pkg::pc_t   mtvec;
  bru_pkg::pc_t   mepc;
  bru_pkg::word_t mcause;
  logic           ecall_fire;

  assign ecall_fire = i_valid & (i_ep_kind == bru_pkg::ECALL);

  // --------------------------------------------------
  // Machine registers
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      mtvec <= `BRU_RESET_MTVEC;
    end else if (i_mtvec_we) begin
      mtvec <= i_mtvec_wdata; // Seen from the next edge on.
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      mepc   <= '0;
      mcause <= '0;
    end else if (ecall_fire) begin
      mepc   <= i_pc;
      mcause <= bru_pkg::word_t'(11); // Environment call from M-mode.
    end
  end

  // --------------------------------------------------
  // Exception next-PC
  // --------------------------------------------------
  always_comb begin
    case (i_ep_kind)
      bru_pkg::ECALL: o_epnpc = mtvec;
      bru_pkg::MRET:  o_epnpc = mepc;
      default:        o_epnpc = mtvec;
    endcase
  end

  assign o_ep_sel = (i_ep_kind == bru_pkg::ECALL) | (i_ep_kind == bru_pkg::MRET);

endmodule

//--- src/fetch_pc.sv
// Program counter register, steps by 4 or loads the resolved branch target.
`include "bru_defs.svh"

module fetch_pc (
  input  logic         i_clk,
  input  logic         i_reset,
  input  logic         i_valid,
  input  logic         i_br_taken,
  input  bru_pkg::pc_t i_br_target,
  output bru_pkg::pc_t o_pc
);

  bru_pkg::pc_t pc_next;

  // --------------------------------------------------
  // Next PC
  // --------------------------------------------------
  assign pc_next = i_br_taken ? i_br_target : o_pc + bru_pkg::pc_t'(4);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_pc <= `BRU_RESET_PC;
    end else if (i_valid) begin
      o_pc <= pc_next; // Holds while no instruction.
    end
  end

endmodule

//--- src/branch_top.sv
// Branch resolution slice top: decoder, trap registers, branch unit and PC register.
module branch_top (
  input  logic            i_clk,
  input  logic            i_reset,
  input  logic            i_valid,
  input  bru_pkg::instr_t i_instr,
  input  bru_pkg::word_t  i_rs1data,
  input  bru_pkg::word_t  i_rs2data,
  input  logic            i_mtvec_we,
  input  bru_pkg::pc_t    i_mtvec_wdata,
  output bru_pkg::pc_t    o_pc,
  output logic            o_br_taken,
  output bru_pkg::pc_t    o_br_target
);

  logic              bren;
  bru_pkg::br_func_e brfunc;
  bru_pkg::imm_t     imm;
  bru_pkg::ep_kind_e ep_kind;
  logic              ep_sel;
  bru_pkg::pc_t      epnpc;

  // --------------------------------------------------
  // Decode and trap
  // --------------------------------------------------
  branch_decode branch_decode_inst (
    .i_instr   (i_instr),
    .o_bren    (bren),
    .o_brfunc  (brfunc),
    .o_imm     (imm),
    .o_ep_kind (ep_kind)
  );

  trap_csr trap_csr_inst (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_valid       (i_valid),
    .i_ep_kind     (ep_kind),
    .i_pc          (o_pc),
    .i_mtvec_we    (i_mtvec_we),
    .i_mtvec_wdata (i_mtvec_wdata),
    .o_ep_sel      (ep_sel),
    .o_epnpc       (epnpc)
  );

  // --------------------------------------------------
  // Resolve and fetch
  // --------------------------------------------------
  branch_unit branch_unit_inst (
    .i_rs1data   (i_rs1data),
    .i_rs2data   (i_rs2data),
    .i_pc        (o_pc),
    .i_imm       (imm),
    .i_bren      (bren),
    .i_brfunc    (brfunc),
    .i_ep_sel    (ep_sel),
    .i_epnpc     (epnpc),
    .o_br_taken  (o_br_taken),
    .o_br_target (o_br_target)
  );

  fetch_pc fetch_pc_inst (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_valid     (i_valid),
    .i_br_taken  (o_br_taken),
    .i_br_target (o_br_target),
    .o_pc        (o_pc)
  );

endmodule

//--- verif/clk_gen.sv
// Testbench clock generator, 4 ns period.
module clk_gen (
  output logic o_clk
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam real HALF_PERIOD = 2.0; // Half of 4 ns.

  initial begin
    o_clk = 1'b0;
  end

  always #(HALF_PERIOD) o_clk = ~o_clk;

endmodule

//--- verif/tb_branch_top.sv
// Table-driven testbench for the branch resolution slice with a PC and trap model.
`include "bru_defs.svh"

module tb_branch_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_ROWS   = 26;
  localparam int MAX_CYCLES = NUM_ROWS * 4 + 50;

  // --------------------------------------------------
  // Table operations
  // --------------------------------------------------
  localparam logic [3:0] OP_BEQ   = 4'd0;
  localparam logic [3:0] OP_BNE   = 4'd1;
  localparam logic [3:0] OP_BLT   = 4'd2;
  localparam logic [3:0] OP_BGE   = 4'd3;
  localparam logic [3:0] OP_BLTU  = 4'd4;
  localparam logic [3:0] OP_BGEU  = 4'd5;
  localparam logic [3:0] OP_JAL   = 4'd6;
  localparam logic [3:0] OP_JALR  = 4'd7;
  localparam logic [3:0] OP_ADDI  = 4'd8;
  localparam logic [3:0] OP_ECALL = 4'd9;
  localparam logic [3:0] OP_MRET  = 4'd10;

  typedef struct packed {
    logic [3:0]  op;
    logic [63:0] imm;
    logic        rnd; // Operands from the LFSR.
    logic [63:0] rs1;
    logic [63:0] rs2;
    logic        mtvec_we;
    logic [63:0] mtvec_wdata;
    logic [1:0]  idle; // Cycles with i_valid low afterwards.
  } row_t;

  logic        clk;
  logic        reset;
  logic        valid;
  logic [31:0] instr;
  logic [63:0] rs1data;
  logic [63:0] rs2data;
  logic        mtvec_we;
  logic [63:0] mtvec_wdata;
  logic [63:0] pc;
  logic        br_taken;
  logic [63:0] br_target;

  row_t        rows [NUM_ROWS];
  logic [63:0] pc_model;
  logic [63:0] mepc_model;
  logic [63:0] mtvec_model;
  logic [31:0] lfsr;
  int          errors = 0;
  int          cycle_count = 0;

  clk_gen clk_gen_inst (
    .o_clk (clk)
  );

  branch_top branch_top_inst (
    .i_clk         (clk),
    .i_reset       (reset),
    .i_valid       (valid),
    .i_instr       (instr),
    .i_rs1data     (rs1data),
    .i_rs2data     (rs2data),
    .i_mtvec_we    (mtvec_we),
    .i_mtvec_wdata (mtvec_wdata),
    .o_pc          (pc),
    .o_br_taken    (br_taken),
    .o_br_target   (br_target)
  );

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1); // Taps 32, 22, 2, 1.
  endfunction

  task automatic draw_word(output logic [63:0] value);
    value = '0;
    for (int i = 0; i < 64; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[62:0], lfsr[0]};
    end
  endtask

  function automatic logic [31:0] encode_instr(input logic [3:0] op, input logic [63:0] imm);
    logic [2:0] f3;
    f3 = (op >= OP_BLT) ? op[2:0] + 3'd2 : op[2:0]; // BEQ 000 up to BGEU 111.
    case (op)
      OP_JAL:   return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
      OP_JALR:  return {imm[11:0], 5'd1, 3'b000, 5'd1, 7'b1100111};
      OP_ADDI:  return {imm[11:0], 5'd1, 3'b000, 5'd1, 7'b0010011};
      OP_ECALL: return 32'h0000_0073;
      OP_MRET:  return 32'h3020_0073;
      default:  return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
    endcase
  endfunction

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Testbench failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // A nonzero write value also raises the mtvec write enable.
  task automatic set_row(input int idx, input logic [3:0] op, input logic [63:0] imm,
                         input logic rnd, input logic [63:0] rs1, input logic [63:0] rs2,
                         input logic [63:0] wdata, input logic [1:0] idle);
    rows[idx] = '{op, imm, rnd, rs1, rs2, (wdata != '0), wdata, idle};
  endtask

  task automatic load_rows();
    set_row(0, OP_BEQ, 64'd16, 1'b0, 64'd5, 64'd5, '0, 2'd0);
    set_row(1, OP_BNE, 64'd16, 1'b0, 64'd5, 64'd5, '0, 2'd1);
    set_row(2, OP_BLT, -64'd8, 1'b0, 64'h8000_0000_0000_0000, '0, '0, 2'd0);
    set_row(3, OP_BGE, 64'd32, 1'b0, 64'h8000_0000_0000_0000, '0, '0, 2'd0);
    set_row(4, OP_BLTU, 64'd24, 1'b0, '0, '1, '0, 2'd0);
    set_row(5, OP_BGEU, -64'd12, 1'b0, '0, '1, '0, 2'd0);
    set_row(6, OP_BLTU, 64'd20, 1'b0, 64'd7, '0, '0, 2'd0);
    set_row(7, OP_BGEU, 64'd20, 1'b0, '0, '0, '0, 2'd0);
    set_row(8, OP_BEQ, 64'd40, 1'b1, '0, '0, '0, 2'd0);
    set_row(9, OP_BNE, -64'd40, 1'b1, '0, '0, '0, 2'd0);
    set_row(10, OP_BLT, 64'd64, 1'b1, '0, '0, '0, 2'd0);
    set_row(11, OP_BGE, -64'd64, 1'b1, '0, '0, '0, 2'd0);
    set_row(12, OP_BLTU, 64'd96, 1'b1, '0, '0, '0, 2'd0);
    set_row(13, OP_BGEU, -64'd96, 1'b1, '0, '0, '0, 2'd2);
    set_row(14, OP_JAL, 64'd2048, 1'b0, '0, '0, '0, 2'd0);
    set_row(15, OP_JAL, -64'd1024, 1'b0, '0, '0, '0, 2'd0);
    set_row(16, OP_JALR, -64'd16, 1'b0, 64'h8000_4000, '0, '0, 2'd0);
    set_row(17, OP_JALR, 64'd100, 1'b1, '0, '0, '0, 2'd0);
    set_row(18, OP_ADDI, 64'd5, 1'b0, '0, '0, '0, 2'd0);
    set_row(19, OP_ECALL, '0, 1'b0, '0, '0, '0, 2'd0);
    set_row(20, OP_MRET, '0, 1'b0, '0, '0, '0, 2'd0);
    set_row(21, OP_ADDI, 64'd1, 1'b0, '0, '0, 64'h8000_2000, 2'd1);
    set_row(22, OP_ECALL, '0, 1'b0, '0, '0, '0, 2'd0);
    set_row(23, OP_ADDI, 64'd1, 1'b0, '0, '0, '0, 2'd0);
    set_row(24, OP_MRET, '0, 1'b0, '0, '0, '0, 2'd0);
    set_row(25, OP_BLT, 64'd8, 1'b1, '0, '0, '0, 2'd1);
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
      $display("Testbench failed");
      $fatal(1, "timeout");
    end
  end

  // --------------------------------------------------
  // Stimulus and checks
  // --------------------------------------------------
  initial begin
    logic [63:0] a;
    logic [63:0] b;
    logic [3:0]  op;
    logic        cond;
    logic [63:0] exp_target;
    reset       = 1'b1;
    valid       = 1'b0;
    instr       = 32'h0000_0013; // NOP.
    rs1data     = '0;
    rs2data     = '0;
    mtvec_we    = 1'b0;
    mtvec_wdata = '0;
    lfsr        = 32'h845c66ab;
    load_rows();
    pc_model    = `BRU_RESET_PC;
    mepc_model  = '0;
    mtvec_model = `BRU_RESET_MTVEC;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_value(pc, pc_model, "PC after reset");
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      op = rows[r].op;
      a  = rows[r].rs1;
      b  = rows[r].rs2;
      if (rows[r].rnd) begin
        draw_word(a);
        draw_word(b);
      end
      @(posedge clk);
      valid       <= 1'b1;
      instr       <= encode_instr(op, rows[r].imm);
      rs1data     <= a;
      rs2data     <= b;
      mtvec_we    <= rows[r].mtvec_we;
      mtvec_wdata <= rows[r].mtvec_wdata;
      case (op)
        OP_BEQ:  cond = (a == b);
        OP_BNE:  cond = (a != b);
        OP_BLT:  cond = ($signed(a) < $signed(b));
        OP_BGE:  cond = ($signed(a) >= $signed(b));
        OP_BLTU: cond = (a < b);
        OP_BGEU: cond = (a >= b);
        OP_ADDI: cond = 1'b0;
        default: cond = 1'b1; // Jumps and trap transfers.
      endcase
      if (op == OP_JALR) exp_target = a + rows[r].imm;
      else if (op == OP_ECALL) exp_target = mtvec_model;
      else if (op == OP_MRET) exp_target = mepc_model;
      else if (cond) exp_target = pc_model + rows[r].imm;
      else exp_target = pc_model + 64'd4;
      @(negedge clk);
      check_value(pc, pc_model, $sformatf("row %0d PC", r));
      check_value({63'd0, br_taken}, {63'd0, cond}, $sformatf("row %0d taken", r));
      check_value(br_target, exp_target, $sformatf("row %0d target", r));
      if (op == OP_ECALL) mepc_model = pc_model;
      if (rows[r].mtvec_we) mtvec_model = rows[r].mtvec_wdata;
      pc_model = cond ? exp_target : pc_model + 64'd4;
      for (int k = 0; k < rows[r].idle; k++) begin
        @(posedge clk);
        valid    <= 1'b0;
        mtvec_we <= 1'b0;
        @(negedge clk);
        check_value(pc, pc_model, $sformatf("row %0d idle PC", r));
      end
    end
    @(posedge clk);
    valid    <= 1'b0;
    mtvec_we <= 1'b0;
    @(negedge clk);
    check_value(pc, pc_model, "final PC");
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+src
src/bru_pkg.sv
src/branch_decode.sv
src/branch_unit.sv
src/trap_csr.sv
src/fetch_pc.sv
src/branch_top.sv
verif/clk_gen.sv
verif/tb_branch_top.sv

//--- Makefile
# Verilator build and run for the branch resolution slice.

VERILATOR ?= verilator
TOP       ?= tb_branch_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) $(VFLAGS)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Testbench passed" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
